// File: adc_meter_tb.sv
/*
 * testbench for the voltage meter, small timing parameters for a short run
 * the I2C model stands in for the ADC and holds the bus pull-ups
 */
`timescale 1ns/100ps
`default_nettype none

module adc_meter_tb
	import adc_pkg::*;
();

	localparam int SCL_DIV = 4;
	localparam int SCAN_CYCLES = 4;
	localparam int DEBOUNCE_CYCLES = 16;
	localparam logic [6:0] DEV_ADDR = 7'b101_0100;
	// start, 8 address bits, ack, 8 data bits, master nack, stop, idle
	localparam int TRANS_CYCLES = 21 * 4 * SCL_DIV;
	localparam int NUM_TESTS = 29;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * TRANS_CYCLES * 4;

	logic sys_clk;
	logic sys_rst_n;
	logic [3:0] key_in;
	logic ack_en;
	sample_t rd_data;
	wire [7:0] led;
	wire seg_t seg_number;
	wire sel_t seg_choice;
	wire scl;
	wire sda;
	int stop_count;

	int err_count;
	int check_count;
	int tests_run;
	int tests_failed;
	int scan_errs;
	int last_pos;
	logic scan_started;
	logic [7:0] visited;
	logic [31:0] rng_state;

	adc_meter_top #(
		.SCL_DIV(SCL_DIV),
		.DEV_ADDR(DEV_ADDR),
		.SCAN_CYCLES(SCAN_CYCLES),
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) uut (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.key_in(key_in),
		.led(led),
		.seg_number(seg_number),
		.seg_choice(seg_choice),
		.scl(scl),
		.sda(sda)
	);

	i2c_adc_model #(
		.DEV_ADDR(DEV_ADDR)
	) adc (
		.scl(scl),
		.sda(sda),
		.ack_en(ack_en),
		.rd_data(rd_data),
		.stop_count(stop_count)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// lit segments g..a, high means on
	function automatic logic [6:0] digit_shape(input int d);
		case (d)
			0: return 7'h3F;
			1: return 7'h06;
			2: return 7'h5B;
			3: return 7'h4F;
			4: return 7'h66;
			5: return 7'h6D;
			6: return 7'h7D;
			7: return 7'h07;
			8: return 7'h7F;
			9: return 7'h6F;
			default: return 7'h00;
		endcase
	endfunction

	// expected pattern at one position, err selects the missing-ACK display
	function automatic seg_t expected_seg(input logic err, input sample_t value, input int pos);
		int v;
		logic [6:0] lit;
		v = int'(value);
		lit = 7'h00;
		if (err) begin
			if (pos < 4)
				lit = 7'h40;
		end else if (pos == 0) begin
			lit = digit_shape(v % 10);
		end else if (pos == 1 && v >= 10) begin
			lit = digit_shape((v / 10) % 10);
		end else if (pos == 2 && v >= 100) begin
			lit = digit_shape(v / 100);
		end
		// active low, decimal point dark
		return {1'b1, ~lit};
	endfunction

	task automatic step(input int n);
		repeat (n) @(posedge sys_clk);
		#1;
	endtask

	task automatic check_seg(input int pos, input seg_t got, input seg_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERROR seg_number at position %0d: got %h expected %h", pos, got, exp);
		end
	endtask

	task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERROR led: got %h expected %h", got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (err_count == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, err_count - errs_before);
		end
	endtask

	// waits past n STOPs plus the digit update
	task automatic wait_stops(input int n);
		int target;
		target = stop_count + n;
		while (stop_count < target)
			@(posedge sys_clk);
		step(4 * SCL_DIV);
	endtask

	// one full scan, starting at a fresh position 0
	task automatic check_display(input logic err, input sample_t value);
		@(negedge sys_clk);
		while (seg_choice == 8'hFE)
			@(negedge sys_clk);
		for (int pos = 0; pos < NUM_DIGITS; pos++) begin
			while (seg_choice != sel_t'(~(8'h01 << pos)))
				@(negedge sys_clk);
			check_seg(pos, seg_number, expected_seg(err, value, pos));
		end
		step(1);
	endtask

	task automatic press_key(input int k);
		key_in[k] = 1'b0;
		step(2 * DEBOUNCE_CYCLES);
		key_in[k] = 1'b1;
		step(2 * DEBOUNCE_CYCLES);
	endtask

	task automatic sample_test(input sample_t value);
		int errs_before;
		errs_before = err_count;
		rd_data = value;
		// the second transaction surely carries the new byte
		wait_stops(2);
		check_display(1'b0, value);
		report_test($sformatf("sample %0d", value), errs_before);
	endtask

	task automatic nack_test();
		int errs_before;
		errs_before = err_count;
		ack_en = 1'b0;
		wait_stops(2);
		check_display(1'b1, 8'd0);
		ack_en = 1'b1;
		report_test("missing ack", errs_before);
	endtask

	task automatic key_test();
		int errs_before;
		errs_before = err_count;
		key_in[2] = 1'b0;
		step(2 * DEBOUNCE_CYCLES);
		check_led(led, 8'h04);
		key_in[2] = 1'b1;
		step(2 * DEBOUNCE_CYCLES);
		check_led(led, 8'h00);
		// glitch shorter than the debounce window
		key_in[2] = 1'b0;
		step(DEBOUNCE_CYCLES / 2);
		key_in[2] = 1'b1;
		for (int i = 0; i < 2 * DEBOUNCE_CYCLES; i++) begin
			step(1);
			check_led(led, 8'h00);
		end
		report_test("key debounce", errs_before);
	endtask

	task automatic hold_test();
		int errs_before;
		errs_before = err_count;
		rd_data = 8'd50;
		wait_stops(2);
		check_display(1'b0, 8'd50);
		press_key(0);
		check_led(led, 8'h10);
		// frozen display ignores the new byte
		rd_data = 8'd201;
		wait_stops(2);
		check_display(1'b0, 8'd50);
		press_key(0);
		check_led(led, 8'h00);
		wait_stops(2);
		check_display(1'b0, 8'd201);
		report_test("hold", errs_before);
	endtask

	task automatic scan_order_report();
		tests_run++;
		if (visited != 8'hFF) begin
			err_count++;
			$display("not every display position was selected during the run");
		end
		if (scan_errs == 0 && visited == 8'hFF) begin
			$display("test scan order: ok");
		end else begin
			tests_failed++;
			$display("test scan order: failed with %0d errors", scan_errs);
		end
	endtask

	// select must be one-cold and step through positions 0 to 7
	always @(negedge sys_clk) begin : scan_monitor
		int pos;
		int zeros;
		if (sys_rst_n && !(seg_choice == 8'hFF && !scan_started)) begin
			zeros = 0;
			pos = 0;
			for (int i = 0; i < NUM_DIGITS; i++) begin
				if (!seg_choice[i]) begin
					zeros++;
					pos = i;
				end
			end
			if (zeros != 1) begin
				err_count++;
				scan_errs++;
				$display("ERROR seg_choice: got %h, expected exactly one low bit", seg_choice);
			end else begin
				if (scan_started && pos != last_pos && pos != (last_pos + 1) % NUM_DIGITS) begin
					err_count++;
					scan_errs++;
					$display("ERROR seg_choice: got %h expected %h", seg_choice,
						sel_t'(~(8'h01 << ((last_pos + 1) % NUM_DIGITS))));
				end
				visited[pos] = 1'b1;
				last_pos = pos;
				scan_started = 1'b1;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("watchdog expired after %0d clock cycles, the run did not finish",
			WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		err_count = 0;
		check_count = 0;
		tests_run = 0;
		tests_failed = 0;
		scan_errs = 0;
		last_pos = 0;
		scan_started = 1'b0;
		visited = 8'h00;
		rng_state = 32'd44;
		sys_rst_n = 1'b0;
		key_in = 4'hF;
		ack_en = 1'b1;
		rd_data = 8'd0;
		step(16);
		sys_rst_n = 1'b1;

		sample_test(8'd0);
		sample_test(8'd7);
		sample_test(8'd42);
		sample_test(8'd100);
		sample_test(8'd255);
		for (int i = 0; i < 20; i++) begin
			rng_state = xorshift32(rng_state);
			sample_test(rng_state[7:0]);
		end
		nack_test();
		key_test();
		hold_test();
		scan_order_report();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, err_count);
		if (err_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: adc_meter_top.sv
/*
 * voltage meter top, defaults assume a 50 MHz board clock
 * 100 kHz SCL, 1 ms per digit, 20 ms debounce
 */
`timescale 1ns/100ps
`default_nettype none

module adc_meter_top
	import adc_pkg::*;
#(
	parameter int SCL_DIV = 125,
	parameter logic [6:0] DEV_ADDR = 7'b101_0100,
	parameter int SCAN_CYCLES = 50000,
	parameter int DEBOUNCE_CYCLES = 1000000
) (
	input wire logic sys_clk,
	input wire logic sys_rst_n,
	input wire logic [3:0] key_in,
	output wire logic [7:0] led,
	output wire seg_t seg_number,
	output wire sel_t seg_choice,
	output wire scl,
	inout wire sda
);

	wire sample_t sample;
	wire logic sample_valid;
	wire logic nack;
	wire logic hold;
	wire logic [NUM_DIGITS*4-1:0] digits;

	i2c_adc_reader #(
		.SCL_DIV(SCL_DIV),
		.DEV_ADDR(DEV_ADDR)
	) u_reader (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.scl(scl),
		.sda(sda),
		.sample(sample),
		.sample_valid(sample_valid),
		.nack(nack)
	);

	adc_to_digits u_digits (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.sample(sample),
		.sample_valid(sample_valid),
		.nack(nack),
		.hold(hold),
		.digits(digits)
	);

	seg_scan #(
		.SCAN_CYCLES(SCAN_CYCLES)
	) u_scan (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.digits(digits),
		.seg_number(seg_number),
		.seg_choice(seg_choice)
	);

	key_debounce #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_keys (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.key_in(key_in),
		.led(led),
		.hold(hold)
	);

endmodule

`default_nettype wire

// File: adc_pkg.sv
/*
 * shared types and digit codes for the voltage meter
 * segment and select patterns are active low
 */
`default_nettype none

package adc_pkg;

	// one ADC conversion result
	typedef logic [7:0] sample_t;

	// display digit code, 0..9 decimal, then blank and dash
	typedef logic [3:0] digit_t;

	// bit 7 is the decimal point, bits 6..0 are segments g..a
	typedef logic [7:0] seg_t;

	// one-hot-zero digit select
	typedef logic [7:0] sel_t;

	localparam digit_t DIGIT_BLANK = 4'd10;
	localparam digit_t DIGIT_DASH = 4'd11;

	// display positions on the board
	localparam int NUM_DIGITS = 8;

endpackage

`default_nettype wire

// File: adc_to_digits.sv
/*
 * sample to decimal digits, leading zeros blanked, dashes on a missing ACK
 * while hold is high all incoming pulses are dropped
 */
`timescale 1ns/100ps
`default_nettype none

module adc_to_digits
	import adc_pkg::*;
(
	input wire logic sys_clk,
	input wire logic sys_rst_n,
	input wire sample_t sample,
	input wire logic sample_valid,
	input wire logic nack,
	input wire logic hold,
	output logic [NUM_DIGITS*4-1:0] digits
);

	digit_t hund;
	digit_t tens;
	digit_t ones;
	digit_t hund_shown;
	digit_t tens_shown;

	always_comb begin
		hund = digit_t'(sample / 8'd100);
		tens = digit_t'((sample / 8'd10) % 8'd10);
		ones = digit_t'(sample % 8'd10);
		hund_shown = (hund == 4'd0) ? DIGIT_BLANK : hund;
		// tens only blanked below 10
		tens_shown = (hund == 4'd0 && tens == 4'd0) ? DIGIT_BLANK : tens;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			digits <= {NUM_DIGITS{DIGIT_BLANK}};
		end else if (!hold) begin
			if (sample_valid)
				digits <= {{(NUM_DIGITS - 3){DIGIT_BLANK}}, hund_shown, tens_shown, ones};
			else if (nack)
				digits <= {{(NUM_DIGITS - 4){DIGIT_BLANK}}, {4{DIGIT_DASH}}};
		end
	end

	for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_code_chk
		assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
			digits[i*4 +: 4] <= DIGIT_DASH);
	end

endmodule

`default_nettype wire

// File: all.f
adc_pkg.sv
i2c_adc_reader.sv
adc_to_digits.sv
seg_scan.sv
key_debounce.sv
adc_meter_top.sv
i2c_adc_model.sv
adc_meter_tb.sv

// File: i2c_adc_model.sv
/*
 * behavioral I2C slave for simulation, single-byte reads only
 * both pull-ups live here, stop_count counts STOP conditions on the bus
 */
`timescale 1ns/100ps
`default_nettype none

module i2c_adc_model
	import adc_pkg::*;
#(
	parameter logic [6:0] DEV_ADDR = 7'b101_0100
) (
	inout wire scl,
	inout wire sda,
	input wire logic ack_en,
	input wire sample_t rd_data,
	output int stop_count
);

	logic drive_low;

	pullup (scl);
	pullup (sda);

	assign sda = drive_low ? 1'b0 : 1'bz;

	// address byte, ack, then the data byte MSB first
	task automatic serve_read();
		logic [7:0] addr_byte;
		sample_t data;
		addr_byte = 8'd0;
		for (int i = 0; i < 8; i++) begin
			@(posedge scl);
			addr_byte = {addr_byte[6:0], sda};
		end
		@(negedge scl);
		if (ack_en && addr_byte == {DEV_ADDR, 1'b1}) begin
			drive_low = 1'b1;
			data = rd_data;
			@(negedge scl);
			for (int i = 7; i >= 0; i--) begin
				drive_low = !data[i];
				@(negedge scl);
			end
			// master drives its NACK next
			drive_low = 1'b0;
		end
	endtask

	// start is sda falling while scl is high
	initial begin
		drive_low = 1'b0;
		forever begin
			@(negedge sda);
			if (scl === 1'b1)
				serve_read();
		end
	end

	initial begin
		stop_count = 0;
		forever begin
			@(posedge sda);
			if (scl === 1'b1)
				stop_count = stop_count + 1;
		end
	end

endmodule

`default_nettype wire

// File: i2c_adc_reader.sv
/*
 * I2C master, single-byte reads from a fixed 7-bit address, no register write
 * no clock stretching and no arbitration; both lines need an external pull-up
 * one bit takes 4*SCL_DIV clocks
 */
`timescale 1ns/100ps
`default_nettype none

module i2c_adc_reader
	import adc_pkg::*;
#(
	parameter int SCL_DIV = 125,
	parameter logic [6:0] DEV_ADDR = 7'b101_0100
) (
	input wire logic sys_clk,
	input wire logic sys_rst_n,
	output wire scl,
	inout wire sda,
	output sample_t sample,
	output logic sample_valid,
	output logic nack
);

	localparam int DIV_W = (SCL_DIV > 1) ? $clog2(SCL_DIV) : 1;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_ADDR,
		ST_ACK,
		ST_DATA,
		ST_MNACK,
		ST_STOP
	} state_t;

	state_t state;
	logic [DIV_W-1:0] div_cnt;
	logic tick;
	logic [1:0] phase;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic ack_high;
	logic scl_low;
	logic sda_low;
	logic [1:0] sda_sync;

	// quarter-bit tick
	assign tick = (div_cnt == DIV_W'(SCL_DIV - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			div_cnt <= '0;
		end else if (tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sda_sync <= 2'b11;
		end else begin
			sda_sync <= {sda_sync[0], sda};
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= ST_IDLE;
			phase <= 2'd0;
			bit_cnt <= 3'd0;
			shift <= 8'd0;
			ack_high <= 1'b0;
			sample <= '0;
			sample_valid <= 1'b0;
			nack <= 1'b0;
		end else begin
			sample_valid <= 1'b0;
			nack <= 1'b0;
			if (tick) begin
				phase <= phase + 2'd1;
				// middle of the scl high time
				if (phase == 2'd1 && state == ST_ACK)
					ack_high <= sda_sync[1];
				if (phase == 2'd1 && state == ST_DATA)
					shift <= {shift[6:0], sda_sync[1]};
				if (phase == 2'd3) begin
					case (state)
						ST_IDLE: state <= ST_START;
						ST_START: begin
							state <= ST_ADDR;
							shift <= {DEV_ADDR, 1'b1};
							bit_cnt <= 3'd0;
						end
						ST_ADDR: begin
							shift <= {shift[6:0], 1'b0};
							bit_cnt <= bit_cnt + 3'd1;
							if (bit_cnt == 3'd7)
								state <= ST_ACK;
						end
						ST_ACK: begin
							bit_cnt <= 3'd0;
							// no slave answered, skip the data byte
							state <= ack_high ? ST_STOP : ST_DATA;
						end
						ST_DATA: begin
							bit_cnt <= bit_cnt + 3'd1;
							if (bit_cnt == 3'd7)
								state <= ST_MNACK;
						end
						ST_MNACK: state <= ST_STOP;
						ST_STOP: begin
							state <= ST_IDLE;
							if (ack_high) begin
								nack <= 1'b1;
							end else begin
								sample <= shift;
								sample_valid <= 1'b1;
							end
						end
						default: state <= ST_IDLE;
					endcase
				end
			end
		end
	end

	// line levels per state and phase, registered so they never glitch
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scl_low <= 1'b0;
			sda_low <= 1'b0;
		end else begin
			case (state)
				ST_START: begin
					scl_low <= (phase == 2'd3);
					sda_low <= phase[1];
				end
				ST_ADDR: begin
					scl_low <= (phase == 2'd0 || phase == 2'd3);
					sda_low <= !shift[7];
				end
				ST_ACK, ST_DATA, ST_MNACK: begin
					scl_low <= (phase == 2'd0 || phase == 2'd3);
					sda_low <= 1'b0;
				end
				ST_STOP: begin
					scl_low <= (phase == 2'd0);
					sda_low <= !phase[1];
				end
				default: begin
					scl_low <= 1'b0;
					sda_low <= 1'b0;
				end
			endcase
		end
	end

	assign scl = scl_low ? 1'b0 : 1'bz;
	assign sda = sda_low ? 1'b0 : 1'bz;

	// one result per transaction
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(sample_valid && nack));

	// bus stays free between transactions
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(state == ST_IDLE) |-> !scl_low);

endmodule

`default_nettype wire

// File: key_debounce.sv
/*
 * four active-low keys, each synchronized then debounced by a stability count
 * a new level is taken after DEBOUNCE_CYCLES stable clocks
 */
`timescale 1ns/100ps
`default_nettype none

module key_debounce #(
	parameter int DEBOUNCE_CYCLES = 1000000
) (
	input wire logic sys_clk,
	input wire logic sys_rst_n,
	input wire logic [3:0] key_in,
	output logic [7:0] led,
	output logic hold
);

	localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

	logic [3:0] sync_a;
	logic [3:0] sync_b;
	logic [3:0] pressed;
	logic pressed0_d;

	// released keys read high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sync_a <= 4'hF;
			sync_b <= 4'hF;
		end else begin
			sync_a <= key_in;
			sync_b <= sync_a;
		end
	end

	for (genvar k = 0; k < 4; k++) begin : g_key
		logic [CNT_W-1:0] cnt;
		logic level;

		always_ff @(posedge sys_clk or negedge sys_rst_n) begin
			if (!sys_rst_n) begin
				cnt <= '0;
				level <= 1'b0;
			end else if (!sync_b[k] == level) begin
				cnt <= '0;
			end else if (cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
				cnt <= '0;
				level <= !sync_b[k];
			end else begin
				cnt <= cnt + 1'b1;
			end
		end

		assign pressed[k] = level;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			pressed0_d <= 1'b0;
			hold <= 1'b0;
			led <= 8'd0;
		end else begin
			pressed0_d <= pressed[0];
			// toggle on the press, not the release
			if (pressed[0] && !pressed0_d)
				hold <= !hold;
			led <= {3'b000, hold, pressed};
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/bash
# builds the meter testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f all.f --top-module adc_meter_tb -o adc_meter_sim \
	&& ./obj_dir/adc_meter_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1

// File: seg_scan.sv
/*
 * eight-digit multiplexed display driver, common segment bus
 * segments and selects are active low, decimal point always dark
 */
`timescale 1ns/100ps
`default_nettype none

module seg_scan
	import adc_pkg::*;
#(
	parameter int SCAN_CYCLES = 50000
) (
	input wire logic sys_clk,
	input wire logic sys_rst_n,
	input wire logic [NUM_DIGITS*4-1:0] digits,
	output seg_t seg_number,
	output sel_t seg_choice
);

	localparam int DWELL_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;
	localparam int POS_W = $clog2(NUM_DIGITS);

	logic [DWELL_W-1:0] dwell_cnt;
	logic [POS_W-1:0] pos;
	digit_t cur_digit;
	seg_t cur_seg;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			dwell_cnt <= '0;
			pos <= '0;
		end else if (dwell_cnt == DWELL_W'(SCAN_CYCLES - 1)) begin
			dwell_cnt <= '0;
			pos <= pos + 1'b1;
		end else begin
			dwell_cnt <= dwell_cnt + 1'b1;
		end
	end

	assign cur_digit = digits[pos*4 +: 4];

	// dp, g..a, low means lit
	always_comb begin
		case (cur_digit)
			4'd0: cur_seg = 8'hC0;
			4'd1: cur_seg = 8'hF9;
			4'd2: cur_seg = 8'hA4;
			4'd3: cur_seg = 8'hB0;
			4'd4: cur_seg = 8'h99;
			4'd5: cur_seg = 8'h92;
			4'd6: cur_seg = 8'h82;
			4'd7: cur_seg = 8'hF8;
			4'd8: cur_seg = 8'h80;
			4'd9: cur_seg = 8'h90;
			DIGIT_DASH: cur_seg = 8'hBF;
			default: cur_seg = 8'hFF;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seg_number <= 8'hFF;
			seg_choice <= 8'hFF;
		end else begin
			seg_number <= cur_seg;
			seg_choice <= ~(sel_t'(1) << pos);
		end
	end

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$onehot0(~seg_choice));

endmodule

`default_nettype wire
